// File: source/display_pkg.sv
// Display compositor shared definitions
// Geometry, pixel codes, bus structs and fill FSM states

package display_pkg;

    // --------------------
    // Geometry and widths
    // --------------------
    localparam int h_active         = 64;                  // Active pixels per line
    localparam int v_active         = 48;                  // Active lines per frame
    localparam int px_cnt_w         = $clog2(h_active);
    localparam int line_cnt_w       = $clog2(v_active);
    localparam int color_w          = 1;                   // Bits per colour channel

    localparam int plot_origin_px   = 8;
    localparam int plot_width       = 32;
    localparam int plot_last_px     = plot_origin_px + plot_width - 1;
    localparam int plot_top_line    = 8;                   // Inclusive
    localparam int plot_height      = 32;
    localparam int plot_bottom_line = plot_top_line + plot_height - 1;  // Inclusive

    localparam int sample_w         = 5;                   // Low bits of acquired sample
    localparam int acq_addr_w       = $clog2(plot_width);
    localparam int line_buff_addr_w = px_cnt_w + 1;        // MSB picks buffer half

    // --------------------
    // Pixel codes
    // --------------------
    typedef logic [1:0] pixel_code_t;

    localparam pixel_code_t code_background = 2'b00;
    localparam pixel_code_t code_plot_empty = 2'b01;
    localparam pixel_code_t code_trace      = 2'b11;

    // --------------------
    // Buses
    // --------------------
    typedef struct packed {
        logic                        wr;
        logic [line_buff_addr_w-1:0] waddr;
        pixel_code_t                 wdata;
    } line_wr_t;

    typedef struct packed {
        logic                  rd;
        logic [acq_addr_w-1:0] raddr;
    } acq_rd_req_t;

    typedef struct packed {
        logic                rvalid;
        logic [sample_w-1:0] rdata;
    } acq_rd_rsp_t;

    typedef struct packed {
        logic [color_w-1:0] r;
        logic [color_w-1:0] g;
        logic [color_w-1:0] b;
    } rgb_t;

    // Line fill FSM
    typedef enum logic [2:0] {
        frame_end,
        wait_acq,
        swap,
        wait_line,
        bg_fill,
        plot_fill
    } fill_state_t;

endpackage

// File: source/plot_area_decoder.sv
// Plot area decoder
// Flags fill positions inside the plot rectangle and turns a sample
// into a filled amplitude trace code for the current line
`timescale 1ns/100ps

module plot_area_decoder
    import display_pkg::*;
(
    input  logic [px_cnt_w-1:0]   px_pos,     // Pixel being filled
    input  logic [line_cnt_w-1:0] fill_line,  // Line being filled
    input  logic [sample_w-1:0]   sample,     // Sample for this column
    output logic                  in_plot,
    output pixel_code_t           code
);

    logic                  px_in;
    logic                  line_in;
    logic [line_cnt_w-1:0] height;

    // --------------------
    // Rectangle test
    // --------------------
    assign px_in   = (px_pos >= px_cnt_w'(plot_origin_px)) &&
                     (px_pos <= px_cnt_w'(plot_last_px));
    assign line_in = (fill_line >= line_cnt_w'(plot_top_line)) &&
                     (fill_line <= line_cnt_w'(plot_bottom_line));

    assign in_plot = px_in && line_in;

    // --------------------
    // Trace code
    // --------------------
    // Height of this line above the plot floor; the trace fills every
    // line from the floor up to the sample amplitude
    assign height = line_cnt_w'(plot_bottom_line) - fill_line;

    assign code = (height <= line_cnt_w'(sample)) ? code_trace : code_plot_empty;

endmodule

// File: source/line_fill_ctrl.sv
// Line fill controller
// Starts one acquisition per frame, then builds each video line into the
// write half of the line buffer and swaps halves once per line
`timescale 1ns/100ps

module line_fill_ctrl
    import display_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        frame_active,
    input  logic        line_active,
    input  logic        run_mode,
    input  logic        acq_done,
    output logic        acq_start,
    output logic        vga_en,
    output acq_rd_req_t acq_req,
    input  acq_rd_rsp_t acq_rsp,
    output line_wr_t    line_wr,
    output logic        buffer_sel
);

    fill_state_t state, state_next;

    logic frame_active_ff, frame_fall;
    logic acq_done_ff, acq_done_rise;

    logic [px_cnt_w-1:0]   px_fill, px_fill_next;
    logic [line_cnt_w-1:0] fill_line, fill_line_next;

    logic                        rd_q, rd_next;
    logic [acq_addr_w-1:0]       raddr_q, raddr_next;
    logic                        wr_q, wr_next;
    logic [line_buff_addr_w-1:0] waddr_q, waddr_next;
    pixel_code_t                 wdata_q, wdata_next;

    logic        buffer_sel_next;
    logic        vga_en_next;
    logic        in_plot;
    pixel_code_t plot_code;

    plot_area_decoder plot_area_decoder_i (
        .px_pos    (px_fill),
        .fill_line (fill_line),
        .sample    (acq_rsp.rdata),
        .in_plot   (in_plot),
        .code      (plot_code)
    );

    assign frame_fall    = !frame_active && frame_active_ff;
    assign acq_done_rise = acq_done && !acq_done_ff;

    // --------------------
    // Fill FSM
    // --------------------
    always_comb begin
        state_next      = state;
        px_fill_next    = px_fill;
        fill_line_next  = fill_line;
        rd_next         = 1'b0;
        raddr_next      = raddr_q;
        wr_next         = 1'b0;
        waddr_next      = waddr_q;
        wdata_next      = wdata_q;
        buffer_sel_next = buffer_sel;
        vga_en_next     = vga_en;

        case (state)
            frame_end: begin
                px_fill_next   = '0;
                fill_line_next = '0;
                state_next     = wait_acq;                 // acq_start pulses here
            end
            wait_acq: begin
                if (acq_done_rise || !run_mode)
                    state_next = bg_fill;
            end
            bg_fill: begin
                if (in_plot) begin                         // Kick off the sample reads
                    rd_next    = 1'b1;
                    raddr_next = '0;
                    state_next = plot_fill;
                end else begin
                    wr_next      = 1'b1;
                    waddr_next   = {buffer_sel, px_fill};
                    wdata_next   = code_background;
                    px_fill_next = px_fill + px_cnt_w'(1);
                    if (px_fill == px_cnt_w'(h_active - 1))
                        state_next = swap;
                end
            end
            plot_fill: begin
                if (rd_q && (raddr_q != acq_addr_w'(plot_width - 1))) begin
                    rd_next    = 1'b1;
                    raddr_next = raddr_q + acq_addr_w'(1);
                end
                if (acq_rsp.rvalid) begin                  // One pixel per returned sample
                    wr_next      = 1'b1;
                    waddr_next   = {buffer_sel, px_fill};
                    wdata_next   = plot_code;
                    px_fill_next = px_fill + px_cnt_w'(1);
                    if (px_fill == px_cnt_w'(plot_last_px))
                        state_next = bg_fill;
                end
            end
            swap: begin
                buffer_sel_next = !buffer_sel;
                vga_en_next     = 1'b1;
                px_fill_next    = '0;
                fill_line_next  = fill_line + line_cnt_w'(1);
                state_next      = wait_line;
            end
            wait_line: begin
                if (line_active)                           // Read side took the last line
                    state_next = bg_fill;
            end
            default: state_next = frame_end;
        endcase

        // A new frame restarts from any state
        if (frame_fall && (state != frame_end)) begin
            state_next = frame_end;
            rd_next    = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= frame_end;
            frame_active_ff <= 1'b0;
            acq_done_ff     <= 1'b0;
            px_fill         <= '0;
            fill_line       <= '0;
            rd_q            <= 1'b0;
            wr_q            <= 1'b0;
            buffer_sel      <= 1'b0;
            vga_en          <= 1'b0;
            acq_start       <= 1'b0;
        end else begin
            state           <= state_next;
            frame_active_ff <= frame_active;
            acq_done_ff     <= acq_done;
            px_fill         <= px_fill_next;
            fill_line       <= fill_line_next;
            rd_q            <= rd_next;
            wr_q            <= wr_next;
            buffer_sel      <= buffer_sel_next;
            vga_en          <= vga_en_next;
            acq_start       <= (state == frame_end);   // frame_end lasts one cycle
        end
    end

    always_ff @(posedge clk) begin
        raddr_q <= raddr_next;
        waddr_q <= waddr_next;
        wdata_q <= wdata_next;
    end

    assign acq_req = '{rd: rd_q, raddr: raddr_q};
    assign line_wr = '{wr: wr_q, waddr: waddr_q, wdata: wdata_q};

endmodule

// File: source/line_buffer.sv
// Line double buffer
// Two halves of one video line each, one write port and a registered read
`timescale 1ns/100ps

module line_buffer
    import display_pkg::*;
(
    input  logic                        clk,
    input  line_wr_t                    line_wr,
    input  logic                        rd,
    input  logic [line_buff_addr_w-1:0] raddr,
    output pixel_code_t                 rdata
);

    pixel_code_t mem [0:2*h_active-1];  // Lower half 0, upper half 1

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (line_wr.wr)
            mem[line_wr.waddr] <= line_wr.wdata;
    end

    // --------------------
    // Read port
    // --------------------
    always_ff @(posedge clk) begin
        if (rd)
            rdata <= mem[raddr];   // Holds last value when idle
    end

endmodule

// File: source/pixel_out.sv
// Pixel output stage
// Scans the display half of the line buffer and maps pixel codes to RGB,
// two cycles after px_cnt
`timescale 1ns/100ps

module pixel_out
    import display_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        line_active,
    input  logic [px_cnt_w-1:0]         px_cnt,
    input  logic                        buffer_sel,   // Half being written
    output logic                        rd,
    output logic [line_buff_addr_w-1:0] raddr,
    input  pixel_code_t                 rdata,
    output rgb_t                        pixel
);

    logic [1:0] line_active_d;
    logic       line_valid;
    rgb_t       rgb_q;

    // Read the half the fill side is not using
    assign raddr = {!buffer_sel, px_cnt};
    assign rd    = line_active;

    // --------------------
    // Line valid delay
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            line_active_d <= '0;
        else
            line_active_d <= {line_active_d[0], line_active};
    end

    assign line_valid = line_active_d[1];   // Aligned with rgb_q

    // Code bit 0 drives red, bit 1 drives green
    always_ff @(posedge clk) begin
        rgb_q.r <= {color_w{rdata[0]}};
        rgb_q.g <= {color_w{rdata[1]}};
        rgb_q.b <= '0;
    end

    assign pixel = line_valid ? rgb_q : '0;

endmodule

// File: source/display_top.sv
// Oscilloscope display compositor top level
// Line fill controller, line double buffer and pixel output stage
`timescale 1ns/100ps

module display_top
    import display_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Video timing
    input  logic                frame_active,
    input  logic                line_active,
    input  logic [px_cnt_w-1:0] px_cnt,
    input  logic                run_mode,
    output logic                vga_en,
    output rgb_t                pixel,
    // Acquisition unit
    output logic                acq_start,
    input  logic                acq_done,
    output acq_rd_req_t         acq_req,
    input  acq_rd_rsp_t         acq_rsp
);

    line_wr_t                    line_wr;
    logic                        buffer_sel;
    logic                        lb_rd;
    logic [line_buff_addr_w-1:0] lb_raddr;
    pixel_code_t                 lb_rdata;

    // --------------------
    // Write side
    // --------------------
    line_fill_ctrl line_fill_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .frame_active (frame_active),
        .line_active  (line_active),
        .run_mode     (run_mode),
        .acq_done     (acq_done),
        .acq_start    (acq_start),
        .vga_en       (vga_en),
        .acq_req      (acq_req),
        .acq_rsp      (acq_rsp),
        .line_wr      (line_wr),
        .buffer_sel   (buffer_sel)
    );

    line_buffer line_buffer_i (
        .clk     (clk),
        .line_wr (line_wr),
        .rd      (lb_rd),
        .raddr   (lb_raddr),
        .rdata   (lb_rdata)
    );

    // --------------------
    // Read side
    // --------------------
    pixel_out pixel_out_i (
        .clk         (clk),
        .rst         (rst),
        .line_active (line_active),
        .px_cnt      (px_cnt),
        .buffer_sel  (buffer_sel),
        .rd          (lb_rd),
        .raddr       (lb_raddr),
        .rdata       (lb_rdata),
        .pixel       (pixel)
    );

endmodule

// File: verification/acq_buffer_model.sv
// Acquisition unit and buffer model
// Raises acq_done some cycles after acq_start and answers reads one cycle later
`timescale 1ns/100ps

module acq_buffer_model
    import display_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           acq_start,
    input  logic                           answer_done,  // Low leaves acq_done unanswered
    input  logic [plot_width*sample_w-1:0] samples,      // Current frame table
    output logic                           acq_done,
    input  acq_rd_req_t                    acq_req,
    output acq_rd_rsp_t                    acq_rsp
);

    localparam int done_delay = 5;

    int done_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acq_done <= 1'b0;
            done_cnt <= 0;
            acq_rsp  <= '0;
        end else begin
            if (acq_start) begin
                acq_done <= 1'b0;
                done_cnt <= answer_done ? done_delay : 0;
            end else if (done_cnt != 0) begin
                done_cnt <= done_cnt - 1;
                if (done_cnt == 1)
                    acq_done <= 1'b1;
            end
            acq_rsp.rvalid <= acq_req.rd;                  // Fixed one-cycle latency
            acq_rsp.rdata  <= samples[acq_req.raddr*sample_w +: sample_w];
        end
    end

endmodule

// File: verification/display_tb.sv
// Display compositor testbench
// Runs a table of frames through the DUT and checks every output pixel
`timescale 1ns/100ps

module display_tb
    import display_pkg::*;
;
    localparam int line_period = 2*h_active + 16;
    localparam int blank_lines = 4;
    localparam int n_frames    = 5;
    localparam int cycle_limit = (n_frames+1) * (v_active+blank_lines) * line_period;

    typedef struct packed {
        logic run_mode;
        logic answer_done;
    } frame_row_t;

    logic clk = 1'b0;
    logic rst, frame_active, line_active, run_mode, vga_en, acq_start, acq_done, answer_done;
    logic [px_cnt_w-1:0]            px_cnt;
    logic [plot_width*sample_w-1:0] samples;
    rgb_t        pixel, exp1, exp2;
    acq_rd_req_t acq_req;
    acq_rd_rsp_t acq_rsp;
    frame_row_t  frame_table [0:n_frames-1];
    logic [31:0] lcg_state;
    logic [acq_addr_w-1:0] next_raddr;
    int rgb_errors, bit_errors, start_cnt;
    int cycles = 0;
    logic done_seen;
    logic drawn;

    always #2 clk = ~clk;

    display_top display_top_i (
        .clk(clk), .rst(rst), .frame_active(frame_active), .line_active(line_active),
        .px_cnt(px_cnt), .run_mode(run_mode), .vga_en(vga_en), .pixel(pixel),
        .acq_start(acq_start), .acq_done(acq_done), .acq_req(acq_req), .acq_rsp(acq_rsp)
    );

    acq_buffer_model acq_buffer_model_i (
        .clk(clk), .rst(rst), .acq_start(acq_start), .answer_done(answer_done),
        .samples(samples), .acq_done(acq_done), .acq_req(acq_req), .acq_rsp(acq_rsp)
    );

    // --------------------
    // Watchdog
    // --------------------
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Filled amplitude trace inside the plot rectangle and black elsewhere
    // A run mode frame that never gets acq_done stays black
    function automatic rgb_t expected_pixel(input logic active, input int px, input int line);
        rgb_t e;
        int   s;
        e = '0;
        if (active && drawn && px >= plot_origin_px && px < plot_origin_px + plot_width &&
            line >= plot_top_line && line <= plot_bottom_line) begin
            s   = samples[(px-plot_origin_px)*sample_w +: sample_w];
            e.r = 1'b1;
            e.g = ((plot_bottom_line - line) <= s);
        end
        return e;
    endfunction

    task automatic check_rgb(input rgb_t actual, input rgb_t expected, input string what);
        if (actual !== expected) begin
            rgb_errors++;
            $display("ERROR %0t ns: %s got r%0d g%0d b%0d, expected r%0d g%0d b%0d", $time,
                     what, actual.r, actual.g, actual.b, expected.r, expected.g, expected.b);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            bit_errors++;
            $display("ERROR %0t ns: %s got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // One clock of checks on the pixel due now and the acquisition side
    task automatic tick();
        @(posedge clk);
        #1;
        check_rgb(pixel, exp2, "pixel");
        if (acq_start)
            start_cnt++;
        if (acq_done)
            done_seen = 1'b1;
        if (acq_req.rd) begin                       // Reads run 0 to plot_width-1 per line
            check_bit(acq_req.raddr == next_raddr, 1'b1, "acq raddr in sequence");
            next_raddr = next_raddr + 1'b1;
        end
        exp2 = exp1;
    endtask

    task automatic drive(input logic fa, input logic la, input int px, input int line);
        tick();
        frame_active = fa;
        line_active  = la;
        px_cnt       = px_cnt_w'(px);
        exp1         = expected_pixel(la, px, line);
    endtask

    task automatic new_samples();
        for (int i = 0; i < plot_width; i++) begin
            lcg_state = lcg_next(lcg_state);
            samples[i*sample_w +: sample_w] = lcg_state[20:16];
        end
    endtask

    initial begin
        frame_table[0] = '{run_mode: 1'b1, answer_done: 1'b1};
        frame_table[1] = '{run_mode: 1'b0, answer_done: 1'b0};  // Free running without acq_done
        frame_table[2] = '{run_mode: 1'b1, answer_done: 1'b0};  // Waits all frame
        frame_table[3] = '{run_mode: 1'b1, answer_done: 1'b1};
        frame_table[4] = '{run_mode: 1'b0, answer_done: 1'b1};
        rgb_errors = 0;
        bit_errors = 0;
        lcg_state  = 32'h2361_b346;
        next_raddr = '0;
        drawn      = 1'b1;
        rst          = 1'b1;
        frame_active = 1'b0;
        line_active  = 1'b0;
        px_cnt       = '0;
        run_mode     = frame_table[0].run_mode;
        answer_done  = frame_table[0].answer_done;
        exp1         = '0;
        exp2         = '0;
        new_samples();

        // --------------------
        // Reset
        // --------------------
        repeat (3) begin
            tick();
            check_bit(vga_en, 1'b0, "vga_en in reset");
            check_bit(acq_start, 1'b0, "acq_start in reset");
            check_bit(acq_req.rd, 1'b0, "acq rd in reset");
        end
        rst = 1'b0;
        #0.5;
        check_bit(vga_en, 1'b0, "vga_en after reset");
        check_bit(acq_start, 1'b0, "acq_start after reset");
        check_bit(acq_req.rd, 1'b0, "acq rd after reset");

        // --------------------
        // Frames
        // --------------------
        for (int f = 0; f < n_frames; f++) begin
            start_cnt   = 0;
            done_seen   = 1'b0;
            run_mode    = frame_table[f].run_mode;
            answer_done = frame_table[f].answer_done;
            drawn       = !(run_mode && !answer_done);
            if (f > 0)
                new_samples();
            repeat (blank_lines*line_period)
                drive(1'b0, 1'b0, 0, 0);                  // First one is the frame_active fall
            for (int line = 0; line < v_active; line++) begin
                for (int px = 0; px < h_active; px++)
                    drive(1'b1, 1'b1, px, line);
                check_bit(vga_en, 1'b1, "vga_en on active line");
                if (line == 0 && run_mode && answer_done)
                    check_bit(done_seen, 1'b1, "acq_done before first line");
                repeat (line_period - h_active)
                    drive(1'b1, 1'b0, 0, line);
            end
            check_bit(start_cnt == 1, 1'b1, "one acq_start per frame");
        end
        repeat (4)
            drive(1'b0, 1'b0, 0, 0);

        $display("Errors: %0d pixel mismatches, %0d bit mismatches", rgb_errors, bit_errors);
        if (rgb_errors == 0 && bit_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: display.f
source/display_pkg.sv
source/plot_area_decoder.sv
source/line_fill_ctrl.sv
source/line_buffer.sv
source/pixel_out.sv
source/display_top.sv
verification/acq_buffer_model.sv
verification/display_tb.sv

// File: Makefile
# Verilator build and run for the display compositor testbench

VERILATOR ?= verilator
TOP       ?= display_tb
FILELIST  ?= display.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG) || \
	   ! grep -q '\*\* PASS \*\*' $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
